/* bench/trap_subsys_chk.sv */
`timescale 1ns/1ps

module trap_subsys_chk (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 busy,
    input logic                 redirect_valid,
    input csr_bus_pkg::wb_req_t wb_req,
    input csr_bus_pkg::wb_rsp_t wb_rsp
);

    // Redirect is a single-cycle pulse
    redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |=> !redirect_valid)
        else $error("redirect_valid stayed high for more than one cycle");

    // Ack needs a request on the previous edge
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("ack raised without cyc and stb on the previous cycle");

    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack stayed high for two cycles");

    // Sequencer leaves reset idle
    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !busy)
        else $error("busy high in the first cycle after reset");

endmodule

bind trap_subsys_top trap_subsys_chk u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .busy           (busy),
    .redirect_valid (redirect_valid),
    .wb_req         (wb_req),
    .wb_rsp         (wb_rsp)
);

/* bench/trap_subsys_tb.sv */
`timescale 1ns/1ps

`include "trap_config.svh"

module trap_subsys_tb;

    localparam int N_CASES = 8;

    // One table row
    // Row names sit in a parallel array
    typedef struct packed {
        logic [`TRAP_XLEN-1:0] pc;
        logic                  mis;
        logic                  jump;
        logic                  mret;
        // Optional mtvec write ahead of the row
        logic                  set_mtvec;
        logic [`TRAP_XLEN-1:0] new_mtvec;
        logic                  exp_trap;
    } case_t;

    logic                  clk;
    logic                  rst_n;
    logic                  id_valid;
    logic [`TRAP_XLEN-1:0] pc_in_id;
    logic                  i_addr_misaligned;
    logic                  jump;
    logic                  mret;
    logic                  busy;
    logic                  redirect_valid;
    logic [`TRAP_XLEN-1:0] redirect_pc;
    csr_bus_pkg::wb_req_t  wb_req;
    csr_bus_pkg::wb_rsp_t  wb_rsp;

    case_t                 cases [N_CASES];
    string                 names [N_CASES];
    integer                seed;
    int                    errors;
    int                    checks;
    // Reference CSR contents
    logic [`TRAP_XLEN-1:0] exp_mtvec;
    logic [`TRAP_XLEN-1:0] exp_mepc;
    logic [`TRAP_XLEN-1:0] exp_mcause;
    logic [`TRAP_XLEN-1:0] exp_mtval;

    trap_subsys_top u_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .id_valid          (id_valid),
        .pc_in_id          (pc_in_id),
        .i_addr_misaligned (i_addr_misaligned),
        .jump              (jump),
        .mret              (mret),
        .busy              (busy),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc),
        .wb_req            (wb_req),
        .wb_rsp            (wb_rsp)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // Inputs change 2 ns after the rising edge
    task automatic next_drive_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [`TRAP_XLEN-1:0] exp,
                               input logic [`TRAP_XLEN-1:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic bus_write(input logic [`TRAP_CSR_AW-1:0] adr,
                             input logic [`TRAP_XLEN-1:0] data);
        int   waited;
        logic got;
        next_drive_slot();
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat_w: data};
        waited = 0;
        got    = 1'b0;
        while (!got && waited < 16)
        begin
            @(negedge clk);
            got = wb_rsp.ack;
            waited++;
        end
        if (!got)
        begin
            errors++;
            $display("bus write to address %0d got no ack in time", adr);
        end
        // Request held through the ack edge
        next_drive_slot();
        wb_req = '0;
    endtask

    task automatic bus_read(input logic [`TRAP_CSR_AW-1:0] adr,
                            output logic [`TRAP_XLEN-1:0] data);
        int   waited;
        logic got;
        next_drive_slot();
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat_w: '0};
        waited = 0;
        got    = 1'b0;
        data   = '0;
        while (!got && waited < 16)
        begin
            @(negedge clk);
            if (wb_rsp.ack)
            begin
                got  = 1'b1;
                data = wb_rsp.dat_r;
            end
            waited++;
        end
        if (!got)
        begin
            errors++;
            $display("bus read from address %0d got no ack in time", adr);
        end
        next_drive_slot();
        wb_req = '0;
    endtask

    // Read back all four trap CSRs against the reference
    task automatic compare_csrs(input string name);
        logic [`TRAP_XLEN-1:0] val;
        bus_read(csr_bus_pkg::MTVEC, val);
        check_value({name, "/mtvec"}, exp_mtvec, val);
        bus_read(csr_bus_pkg::MEPC, val);
        check_value({name, "/mepc"}, exp_mepc, val);
        bus_read(csr_bus_pkg::MCAUSE, val);
        check_value({name, "/mcause"}, exp_mcause, val);
        bus_read(csr_bus_pkg::MTVAL, val);
        check_value({name, "/mtval"}, exp_mtval, val);
    endtask

    // Random word-aligned pc
    // Misaligned rows get bit 1 set
    function automatic case_t make_case(input logic mis, input logic jmp, input logic ret,
                                        input logic set_tv, input logic [`TRAP_XLEN-1:0] tv,
                                        input logic trap);
        case_t c;
        c.pc        = $random(seed);
        c.pc[1:0]   = mis ? 2'b10 : 2'b00;
        c.mis       = mis;
        c.jump      = jmp;
        c.mret      = ret;
        c.set_mtvec = set_tv;
        c.new_mtvec = tv;
        c.exp_trap  = trap;
        return c;
    endfunction

    task automatic run_case(input int i);
        logic                  exp_redirect;
        logic [`TRAP_XLEN-1:0] exp_target;
        logic                  seen;
        int                    waited;
        if (cases[i].set_mtvec)
        begin
            bus_write(csr_bus_pkg::MTVEC, cases[i].new_mtvec);
            exp_mtvec = cases[i].new_mtvec;
        end
        // Trap beats mret
        // mret returns to the old mepc
        exp_redirect = cases[i].exp_trap || cases[i].mret;
        exp_target   = cases[i].exp_trap ? exp_mtvec : exp_mepc;
        next_drive_slot();
        id_valid          = 1'b1;
        pc_in_id          = cases[i].pc;
        i_addr_misaligned = cases[i].mis;
        jump              = cases[i].jump;
        mret              = cases[i].mret;
        next_drive_slot();
        id_valid          = 1'b0;
        i_addr_misaligned = 1'b0;
        jump              = 1'b0;
        mret              = 1'b0;
        // Sequencer leaves idle on the edge that took the row
        check_value({names[i], "/busy"}, exp_redirect, busy);
        seen   = 1'b0;
        waited = 0;
        if (exp_redirect)
        begin
            while (!seen && waited < 10)
            begin
                @(negedge clk);
                seen = redirect_valid;
                waited++;
            end
            if (!seen)
            begin
                errors++;
                $display("no redirect arrived in time for %s", names[i]);
            end
            else
                check_value({names[i], "/redirect_pc"}, exp_target, redirect_pc);
        end
        else
        begin
            // Watch five cycles for a stray redirect
            repeat (5)
            begin
                @(negedge clk);
                check_value({names[i], "/redirect_valid"}, 1'b0, redirect_valid);
            end
        end
        if (cases[i].exp_trap)
        begin
            exp_mepc   = cases[i].pc;
            exp_mtval  = cases[i].pc;
            exp_mcause = 32'd1;
        end
        compare_csrs(names[i]);
    endtask

    initial
    begin
        logic [`TRAP_XLEN-1:0] cyc_val;
        logic [`TRAP_XLEN-1:0] cyc_set;
        clk               = 1'b0;
        rst_n             = 1'b0;
        id_valid          = 1'b0;
        pc_in_id          = '0;
        i_addr_misaligned = 1'b0;
        jump              = 1'b0;
        mret              = 1'b0;
        wb_req            = '0;
        seed              = 99369;
        errors            = 0;
        checks            = 0;
        exp_mtvec         = `TRAP_MTVEC_RESET;
        exp_mepc          = '0;
        exp_mcause        = '0;
        exp_mtval         = '0;

        names[0] = "mis_trap";
        cases[0] = make_case(1, 0, 0, 0, 0, 1);
        names[1] = "mis_with_jump";
        cases[1] = make_case(1, 1, 0, 0, 0, 0);
        names[2] = "aligned";
        cases[2] = make_case(0, 0, 0, 0, 0, 0);
        names[3] = "mret_first";
        cases[3] = make_case(0, 0, 1, 0, 0, 0);
        names[4] = "new_mtvec_trap";
        cases[4] = make_case(1, 0, 0, 1, 32'h0000_2000, 1);
        names[5] = "jump_only";
        cases[5] = make_case(0, 1, 0, 0, 0, 0);
        names[6] = "trap_beats_mret";
        cases[6] = make_case(1, 0, 1, 0, 0, 1);
        names[7] = "mret_last";
        cases[7] = make_case(0, 0, 1, 0, 0, 0);

        // Reset for 10 cycles
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("reset/busy", 1'b0, busy);
        check_value("reset/redirect_valid", 1'b0, redirect_valid);
        compare_csrs("reset");

        for (int i = 0; i < N_CASES; i++)
            run_case(i);

        // Counter load then read back a little later
        cyc_set = 32'h0000_4000;
        bus_write(csr_bus_pkg::MCYCLE_LO, cyc_set);
        bus_read(csr_bus_pkg::MCYCLE_LO, cyc_val);
        checks++;
        assert (cyc_val > cyc_set && cyc_val < cyc_set + 20)
        else
        begin
            errors++;
            $display("error mcycle_lo expected %h..%h actual %h", cyc_set + 1, cyc_set + 19,
                     cyc_val);
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* include/trap_config.svh */
`ifndef TRAP_CONFIG_SVH
`define TRAP_CONFIG_SVH

// Data and PC width
`define TRAP_XLEN 32

// Wishbone word address width
// Covers the six CSR slots plus two unmapped ones
`define TRAP_CSR_AW 3

// epc value shown while no exception is raised
`define TRAP_RESET_VECTOR 32'h0001_0000

// Trap handler base out of reset
`define TRAP_MTVEC_RESET 32'h0000_0100

// mcycle is always a full 64-bit count
`define TRAP_CYCLE_W 64

`endif

/* logic/csr_bus_pkg.sv */
package csr_bus_pkg;

    `include "trap_config.svh"

    // Wishbone classic request, master to slave
    // Held steady by the master until ack
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        // Word address into the CSR map
        logic [`TRAP_CSR_AW-1:0] adr;
        logic [`TRAP_XLEN-1:0]   dat_w;
    } wb_req_t;

    // Wishbone classic response, slave to master
    typedef struct packed {
        // Single-cycle ack
        logic                  ack;
        // Valid while ack is high
        logic [`TRAP_XLEN-1:0] dat_r;
    } wb_rsp_t;

    // CSR word address map
    // Slots 6 and 7 are unmapped and read zero
    typedef enum logic [`TRAP_CSR_AW-1:0] {
        MTVEC     = 3'd0,
        MEPC      = 3'd1,
        MCAUSE    = 3'd2,
        MTVAL     = 3'd3,
        MCYCLE_LO = 3'd4,
        MCYCLE_HI = 3'd5
    } csr_addr_e;

    // Bus write into one half of mcycle
    typedef struct packed {
        logic                  lo_we;
        logic                  hi_we;
        logic [`TRAP_XLEN-1:0] data;
    } cnt_wr_t;

endpackage

/* logic/cycle_counter.sv */
`timescale 1ns/1ps

`include "trap_config.svh"

module cycle_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    // Half-word loads decoded by the CSR file
    input  csr_bus_pkg::cnt_wr_t     cnt_wr,
    output logic [`TRAP_CYCLE_W-1:0] mcycle
);

    logic [`TRAP_CYCLE_W-1:0] count_inc;

    // Carry from the low half still reaches the high half
    assign count_inc = mcycle + `TRAP_CYCLE_W'(1);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mcycle <= '0;
        end
        else
        begin
            mcycle <= count_inc;
            // Loaded half takes the bus data
            // The other half keeps counting
            if (cnt_wr.lo_we)
                mcycle[`TRAP_XLEN-1:0] <= cnt_wr.data;
            if (cnt_wr.hi_we)
                mcycle[`TRAP_CYCLE_W-1:`TRAP_XLEN] <= cnt_wr.data;
        end
    end

endmodule

/* logic/exception_ctrl_u.sv */
`timescale 1ns/1ps

`include "trap_config.svh"

module exception_ctrl_u (
    // PC of the instruction now in ID
    input  logic [`TRAP_XLEN-1:0] pc_in_id,
    // Misaligned fetch flag carried over from IF
    input  logic                  i_addr_misaligned,
    // Instruction ahead resolved as a taken jump
    input  logic                  jump,
    output logic                  exception_raised,
    output trap_pkg::trap_rec_t   exception
);

    trap_pkg::exc_cause_e cause;

    // Cause selection
    always_comb
    begin
        // Jump wins, this fetch is flushed anyway
        if (jump)
            cause = trap_pkg::EXC_NONE;
        else if (i_addr_misaligned)
            cause = trap_pkg::EXC_I_ADDR_MISALIGNED;
        else
            cause = trap_pkg::EXC_NONE;
    end

    // epc and tval follow from the cause alone
    always_comb
    begin
        exception.cause = cause;
        if (cause == trap_pkg::EXC_NONE)
            exception.epc = `TRAP_RESET_VECTOR;
        else
            exception.epc = pc_in_id;
        case (cause)
            // Misaligned target is the fetch PC itself
            trap_pkg::EXC_I_ADDR_MISALIGNED: exception.tval = pc_in_id;
            default:                         exception.tval = '0;
        endcase
    end

    assign exception_raised = cause != trap_pkg::EXC_NONE;

endmodule

/* logic/trap_csr_file.sv */
`timescale 1ns/1ps

`include "trap_config.svh"

module trap_csr_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  csr_bus_pkg::wb_req_t     wb_req,
    output csr_bus_pkg::wb_rsp_t     wb_rsp,
    // Trap commit from the sequencer
    input  logic                     commit,
    input  trap_pkg::trap_rec_t      trap_rec,
    input  logic [`TRAP_CYCLE_W-1:0] mcycle,
    output csr_bus_pkg::cnt_wr_t     cnt_wr,
    output logic [`TRAP_XLEN-1:0]    mtvec,
    output logic [`TRAP_XLEN-1:0]    mepc
);

    trap_pkg::exc_cause_e   mcause;
    logic [`TRAP_XLEN-1:0]  mtval;
    csr_bus_pkg::csr_addr_e addr;
    logic                   ack_q;
    logic                   acc;
    logic                   wr_en;
    logic [`TRAP_XLEN-1:0]  rdata_nxt;
    logic [`TRAP_XLEN-1:0]  rdata_q;

    // New access: cyc and stb seen while ack is low
    assign acc   = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr_en = acc && wb_req.we;
    assign addr  = csr_bus_pkg::csr_addr_e'(wb_req.adr);

    // Counter halves live in the counter block
    assign cnt_wr.lo_we = wr_en && (addr == csr_bus_pkg::MCYCLE_LO);
    assign cnt_wr.hi_we = wr_en && (addr == csr_bus_pkg::MCYCLE_HI);
    assign cnt_wr.data  = wb_req.dat_w;

    // Ack one cycle after the request starts
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ack_q <= 1'b0;
        else
            ack_q <= acc;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mtvec  <= `TRAP_MTVEC_RESET;
            mepc   <= '0;
            mcause <= trap_pkg::EXC_NONE;
            mtval  <= '0;
        end
        else
        begin
            // mtvec is bus-only
            if (wr_en && addr == csr_bus_pkg::MTVEC)
                mtvec <= wb_req.dat_w;
            // Commit beats a bus write on the same edge
            if (commit)
            begin
                mepc   <= trap_rec.epc;
                mcause <= trap_rec.cause;
                mtval  <= trap_rec.tval;
            end
            else if (wr_en)
            begin
                case (addr)
                    csr_bus_pkg::MEPC:   mepc <= wb_req.dat_w;
                    // Only the low cause bits are stored
                    csr_bus_pkg::MCAUSE:
                        mcause <= trap_pkg::exc_cause_e'(wb_req.dat_w[1:0]);
                    csr_bus_pkg::MTVAL:  mtval <= wb_req.dat_w;
                    default:             ;
                endcase
            end
        end
    end

    // Read mux, unmapped slots give zero
    always_comb
    begin
        case (addr)
            csr_bus_pkg::MTVEC:     rdata_nxt = mtvec;
            csr_bus_pkg::MEPC:      rdata_nxt = mepc;
            csr_bus_pkg::MCAUSE:    rdata_nxt = {{(`TRAP_XLEN-2){1'b0}}, mcause};
            csr_bus_pkg::MTVAL:     rdata_nxt = mtval;
            csr_bus_pkg::MCYCLE_LO: rdata_nxt = mcycle[`TRAP_XLEN-1:0];
            csr_bus_pkg::MCYCLE_HI: rdata_nxt = mcycle[`TRAP_CYCLE_W-1:`TRAP_XLEN];
            default:                rdata_nxt = '0;
        endcase
    end

    // Read data captured with the ack
    always_ff @(posedge clk)
    begin
        if (acc)
            rdata_q <= rdata_nxt;
    end

    assign wb_rsp = '{ack: ack_q, dat_r: rdata_q};

endmodule

/* logic/trap_fsm.sv */
`timescale 1ns/1ps

`include "trap_config.svh"

module trap_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  id_valid,
    input  logic                  mret,
    input  logic                  exception_raised,
    input  trap_pkg::trap_rec_t   exception,
    // Current CSR values read back from the CSR file
    input  logic [`TRAP_XLEN-1:0] mtvec,
    input  logic [`TRAP_XLEN-1:0] mepc,
    output logic                  commit,
    output trap_pkg::trap_rec_t   trap_rec,
    output logic                  busy,
    output logic                  redirect_valid,
    output logic [`TRAP_XLEN-1:0] redirect_pc
);

    trap_pkg::trap_state_e state;
    trap_pkg::trap_state_e state_nxt;
    // Target select, 1 for mepc on MRET
    logic                  ret_sel;
    logic                  take_trap;
    logic                  leave_idle;

    // Exception only counts with a valid ID slot
    assign take_trap = id_valid && exception_raised;

    always_comb
    begin
        state_nxt = state;
        case (state)
            trap_pkg::TS_IDLE:
            begin
                // Trap has priority over MRET
                if (take_trap)
                    state_nxt = trap_pkg::TS_COMMIT;
                else if (mret)
                    state_nxt = trap_pkg::TS_REDIRECT;
            end
            trap_pkg::TS_COMMIT:   state_nxt = trap_pkg::TS_REDIRECT;
            trap_pkg::TS_REDIRECT: state_nxt = trap_pkg::TS_IDLE;
            default:               state_nxt = trap_pkg::TS_IDLE;
        endcase
    end

    assign leave_idle = (state == trap_pkg::TS_IDLE) && (state_nxt != trap_pkg::TS_IDLE);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state          <= trap_pkg::TS_IDLE;
            redirect_valid <= 1'b0;
            ret_sel        <= 1'b0;
        end
        else
        begin
            state          <= state_nxt;
            // One-cycle pulse, state is back in idle by then
            redirect_valid <= state == trap_pkg::TS_REDIRECT;
            if (leave_idle)
                ret_sel <= !take_trap;
        end
    end

    // Trap record and target, no reset needed
    always_ff @(posedge clk)
    begin
        if (state == trap_pkg::TS_IDLE && take_trap)
            trap_rec <= exception;
        // mtvec is sampled after the commit edge
        if (state == trap_pkg::TS_REDIRECT)
            redirect_pc <= ret_sel ? mepc : mtvec;
    end

    // CSR write strobe for the whole commit cycle
    assign commit = state == trap_pkg::TS_COMMIT;
    // Pipeline stalls outside idle
    assign busy   = state != trap_pkg::TS_IDLE;

endmodule

/* logic/trap_pkg.sv */
package trap_pkg;

    `include "trap_config.svh"

    // Machine exception cause codes
    // Only the fetch misalignment is detected here
    typedef enum logic [1:0] {
        EXC_NONE              = 2'd0,
        EXC_I_ADDR_MISALIGNED = 2'd1
    } exc_cause_e;

    // Trap sequencer states
    typedef enum logic [1:0] {
        TS_IDLE,
        TS_COMMIT,
        TS_REDIRECT
    } trap_state_e;

    // One trap event as seen in ID
    typedef struct packed {
        // Why the trap happened
        exc_cause_e            cause;
        // PC of the faulting instruction
        logic [`TRAP_XLEN-1:0] epc;
        // Faulting address for misalignment
        logic [`TRAP_XLEN-1:0] tval;
    } trap_rec_t;

endpackage

/* logic/trap_subsys_top.sv */
`timescale 1ns/1ps

`include "trap_config.svh"

module trap_subsys_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // Pipeline side
    input  logic                  id_valid,
    input  logic [`TRAP_XLEN-1:0] pc_in_id,
    input  logic                  i_addr_misaligned,
    input  logic                  jump,
    input  logic                  mret,
    output logic                  busy,
    output logic                  redirect_valid,
    output logic [`TRAP_XLEN-1:0] redirect_pc,
    // CSR bus
    input  csr_bus_pkg::wb_req_t  wb_req,
    output csr_bus_pkg::wb_rsp_t  wb_rsp
);

    logic                     exception_raised;
    trap_pkg::trap_rec_t      exception;
    logic                     commit;
    trap_pkg::trap_rec_t      trap_rec;
    logic [`TRAP_XLEN-1:0]    mtvec;
    logic [`TRAP_XLEN-1:0]    mepc;
    csr_bus_pkg::cnt_wr_t     cnt_wr;
    logic [`TRAP_CYCLE_W-1:0] mcycle;

    // ID-stage decision, zero latency
    exception_ctrl_u u_exc (
        .pc_in_id          (pc_in_id),
        .i_addr_misaligned (i_addr_misaligned),
        .jump              (jump),
        .exception_raised  (exception_raised),
        .exception         (exception)
    );

    trap_fsm u_fsm (
        .clk              (clk),
        .rst_n            (rst_n),
        .id_valid         (id_valid),
        .mret             (mret),
        .exception_raised (exception_raised),
        .exception        (exception),
        .mtvec            (mtvec),
        .mepc             (mepc),
        .commit           (commit),
        .trap_rec         (trap_rec),
        .busy             (busy),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc)
    );

    cycle_counter u_cnt (
        .clk    (clk),
        .rst_n  (rst_n),
        .cnt_wr (cnt_wr),
        .mcycle (mcycle)
    );

    trap_csr_file u_csr (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .commit   (commit),
        .trap_rec (trap_rec),
        .mcycle   (mcycle),
        .cnt_wr   (cnt_wr),
        .mtvec    (mtvec),
        .mepc     (mepc)
    );

endmodule

/* trap_unit.f */
+incdir+include
logic/trap_pkg.sv
logic/csr_bus_pkg.sv
logic/exception_ctrl_u.sv
logic/trap_fsm.sv
logic/cycle_counter.sv
logic/trap_csr_file.sv
logic/trap_subsys_top.sv
bench/trap_subsys_chk.sv
bench/trap_subsys_tb.sv
